/* rtl/loader_pkg.sv */
package loader_pkg;

    // program word and memory geometry
    localparam int WORD_WIDTH = 16;
    localparam int ADDR_WIDTH = 8;
    localparam int RAM_DEPTH = 256;
    localparam logic [ADDR_WIDTH-1:0] LAST_ADDR = ADDR_WIDTH'(RAM_DEPTH - 1);

    // uart bit timing, in sysclk cycles
    localparam int CLKS_PER_BIT = 8;
    localparam int BIT_CNT_WIDTH = $clog2(CLKS_PER_BIT);
    localparam logic [BIT_CNT_WIDTH-1:0] BIT_LAST = BIT_CNT_WIDTH'(CLKS_PER_BIT - 1);
    localparam logic [BIT_CNT_WIDTH-1:0] BIT_HALF = BIT_CNT_WIDTH'(CLKS_PER_BIT / 2 - 1);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    typedef enum logic {
        RAM_CLEAR,
        RAM_READY
    } ram_state_t;

    // active low segments, gfedcba, indexed by hex value
    localparam logic [6:0] SEG_TABLE [16] = '{
        7'h40, 7'h79, 7'h24, 7'h30,
        7'h19, 7'h12, 7'h02, 7'h78,
        7'h00, 7'h10, 7'h08, 7'h03,
        7'h46, 7'h21, 7'h06, 7'h0e
    };

endpackage

/* rtl/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx (
    input  logic       sysclk,
    input  logic       sysrst,
    input  logic       rx,
    output logic       byte_valid,
    output logic [7:0] byte_data
);
    import loader_pkg::*;

    rx_state_t state;
    logic [1:0] rx_sync;
    logic [BIT_CNT_WIDTH-1:0] bit_cnt;
    logic [2:0] bit_idx;
    logic rx_s;

    assign rx_s = rx_sync[1];

    // line idles high
    always_ff @(posedge sysclk) begin
        if (!sysrst) begin
            rx_sync <= 2'b11;
        end else begin
            rx_sync <= {rx_sync[0], rx};
        end
    end

    always_ff @(posedge sysclk) begin
        if (!sysrst) begin
            state      <= RX_IDLE;
            bit_cnt    <= '0;
            bit_idx    <= '0;
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    bit_cnt <= '0;
                    if (!rx_s) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    // half a bit in, the line must still be low
                    if (bit_cnt == BIT_HALF) begin
                        bit_cnt <= '0;
                        bit_idx <= '0;
                        state   <= rx_s ? RX_IDLE : RX_DATA;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (bit_cnt == BIT_LAST) begin
                        bit_cnt <= '0;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                        bit_idx <= bit_idx + 1'b1;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (bit_cnt == BIT_LAST) begin
                        // framing error drops the byte
                        byte_valid <= rx_s;
                        bit_cnt    <= '0;
                        state      <= RX_IDLE;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // lsb first, sampled mid bit
    always_ff @(posedge sysclk) begin
        if (state == RX_DATA && bit_cnt == BIT_LAST) begin
            byte_data <= {rx_s, byte_data[7:1]};
        end
    end

    a_single_strobe: assert property (@(posedge sysclk) disable iff (!sysrst)
        byte_valid |=> !byte_valid);

endmodule

/* rtl/word_assembler.sv */
`timescale 1ns/1ps

module word_assembler (
    input  logic                              sysclk,
    input  logic                              sysrst,
    input  logic                              byte_valid,
    input  logic [7:0]                        byte_data,
    input  logic                              restart,
    output logic                              word_valid,
    output logic [loader_pkg::WORD_WIDTH-1:0] word_data
);
    import loader_pkg::*;

    // high when the high byte is held and the low byte is due
    logic phase;
    logic [7:0] high_byte;
    logic take_high;
    logic take_low;

    // a restart in the same cycle makes this byte the high one
    assign take_high = byte_valid && (!phase || restart);
    assign take_low  = byte_valid && phase && !restart;

    always_ff @(posedge sysclk) begin
        if (!sysrst) begin
            phase      <= 1'b0;
            word_valid <= 1'b0;
        end else begin
            word_valid <= take_low;
            if (take_high) begin
                phase <= 1'b1;
            end else if (take_low || restart) begin
                phase <= 1'b0;
            end
        end
    end

    always_ff @(posedge sysclk) begin
        if (take_high) begin
            high_byte <= byte_data;
        end
        if (take_low) begin
            word_data <= {high_byte, byte_data};
        end
    end

endmodule

/* rtl/load_sequencer.sv */
`timescale 1ns/1ps

module load_sequencer (
    input  logic                              sysclk,
    input  logic                              sysrst,
    input  logic                              load_en,
    input  logic                              word_valid,
    input  logic [loader_pkg::WORD_WIDTH-1:0] word_data,
    input  logic                              mem_ready,
    output logic                              wr_en,
    output logic [loader_pkg::ADDR_WIDTH-1:0] wr_addr,
    output logic [loader_pkg::WORD_WIDTH-1:0] wr_data,
    output logic                              restart,
    output logic [loader_pkg::ADDR_WIDTH-1:0] load_addr,
    output logic [loader_pkg::WORD_WIDTH-1:0] last_word
);
    import loader_pkg::*;

    logic [1:0] load_sync;
    logic load_prev;
    logic load_on;
    logic load_rise;
    logic accept;
    logic [ADDR_WIDTH-1:0] base_addr;

    assign load_on   = load_sync[1];
    assign load_rise = load_on && !load_prev;
    assign accept    = word_valid && load_on && mem_ready;

    // switch turning on restarts from address zero
    assign base_addr = load_rise ? '0 : load_addr;

    always_ff @(posedge sysclk) begin
        if (!sysrst) begin
            load_sync <= 2'b00;
            load_prev <= 1'b0;
            restart   <= 1'b0;
            wr_en     <= 1'b0;
            load_addr <= '0;
            last_word <= '0;
        end else begin
            load_sync <= {load_sync[0], load_en};
            load_prev <= load_on;
            restart   <= load_rise;
            wr_en     <= accept;
            if (accept) begin
                // wraps past the top of memory
                load_addr <= base_addr + 1'b1;
                last_word <= word_data;
            end else if (load_rise) begin
                load_addr <= '0;
            end
        end
    end

    always_ff @(posedge sysclk) begin
        if (accept) begin
            wr_addr <= base_addr;
            wr_data <= word_data;
        end
    end

    // no write may reach the memory while it is still clearing
    a_write_when_ready: assert property (@(posedge sysclk) disable iff (!sysrst)
        wr_en |-> mem_ready);

endmodule

/* rtl/program_ram.sv */
`timescale 1ns/1ps

module program_ram (
    input  logic                              sysclk,
    input  logic                              sysrst,
    input  logic                              wr_en,
    input  logic [loader_pkg::ADDR_WIDTH-1:0] wr_addr,
    input  logic [loader_pkg::WORD_WIDTH-1:0] wr_data,
    input  logic [loader_pkg::ADDR_WIDTH-1:0] rd_addr,
    output logic [loader_pkg::WORD_WIDTH-1:0] rd_data,
    output logic                              mem_ready
);
    import loader_pkg::*;

    ram_state_t state;
    logic [ADDR_WIDTH-1:0] clr_addr;
    logic [WORD_WIDTH-1:0] mem [RAM_DEPTH];

    assign mem_ready = (state == RAM_READY);

    // one address cleared per cycle after reset
    always_ff @(posedge sysclk) begin
        if (!sysrst) begin
            state    <= RAM_CLEAR;
            clr_addr <= '0;
        end else begin
            case (state)
                RAM_CLEAR: begin
                    clr_addr <= clr_addr + 1'b1;
                    if (clr_addr == LAST_ADDR) begin
                        state <= RAM_READY;
                    end
                end
                RAM_READY: begin
                    state <= RAM_READY;
                end
                default: state <= RAM_CLEAR;
            endcase
        end
    end

    // the sweep owns the write port until it is done
    always_ff @(posedge sysclk) begin
        if (state == RAM_CLEAR) begin
            mem[clr_addr] <= '0;
        end else if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    always_ff @(posedge sysclk) begin
        rd_data <= mem[rd_addr];
    end

    a_ready_holds: assert property (@(posedge sysclk) disable iff (!sysrst)
        mem_ready |=> mem_ready);

endmodule

/* rtl/hex_seg_display.sv */
`timescale 1ns/1ps

module hex_seg_display (
    input  logic [loader_pkg::ADDR_WIDTH-1:0] load_addr,
    input  logic [loader_pkg::WORD_WIDTH-1:0] last_word,
    output logic [7:0]                        hex0,
    output logic [7:0]                        hex1,
    output logic [7:0]                        hex2,
    output logic [7:0]                        hex3,
    output logic [7:0]                        hex4,
    output logic [7:0]                        hex5
);
    import loader_pkg::*;

    // decimal point in bit 7, held off
    function automatic logic [7:0] seg_digit(input logic [3:0] nibble);
        seg_digit = {1'b1, SEG_TABLE[nibble]};
    endfunction

    logic [3:0] addr_hi;
    logic [3:0] addr_lo;

    // address is two digits wide
    assign addr_hi = load_addr[7:4];
    assign addr_lo = load_addr[3:0];

    always_comb begin
        hex5 = seg_digit(addr_hi);
        hex4 = seg_digit(addr_lo);
        hex3 = seg_digit(last_word[15:12]);
        hex2 = seg_digit(last_word[11:8]);
        hex1 = seg_digit(last_word[7:4]);
        hex0 = seg_digit(last_word[3:0]);
    end

endmodule

/* rtl/program_loader.sv */
`timescale 1ns/1ps

module program_loader (
    input  logic                              sysclk,
    input  logic                              sysrst,
    input  logic                              rx,
    input  logic                              load_en,
    input  logic [loader_pkg::ADDR_WIDTH-1:0] rd_addr,
    output logic [loader_pkg::WORD_WIDTH-1:0] rd_data,
    output logic                              mem_ready,
    output logic [7:0]                        hex0,
    output logic [7:0]                        hex1,
    output logic [7:0]                        hex2,
    output logic [7:0]                        hex3,
    output logic [7:0]                        hex4,
    output logic [7:0]                        hex5
);
    import loader_pkg::*;

    logic                  byte_valid;
    logic [7:0]            byte_data;
    logic                  word_valid;
    logic [WORD_WIDTH-1:0] word_data;
    logic                  restart;
    logic                  wr_en;
    logic [ADDR_WIDTH-1:0] wr_addr;
    logic [WORD_WIDTH-1:0] wr_data;
    logic [ADDR_WIDTH-1:0] load_addr;
    logic [WORD_WIDTH-1:0] last_word;

    uart_rx u_uart_rx (
        .sysclk     (sysclk),
        .sysrst     (sysrst),
        .rx         (rx),
        .byte_valid (byte_valid),
        .byte_data  (byte_data)
    );

    word_assembler u_word_assembler (
        .sysclk     (sysclk),
        .sysrst     (sysrst),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .restart    (restart),
        .word_valid (word_valid),
        .word_data  (word_data)
    );

    load_sequencer u_load_sequencer (
        .sysclk     (sysclk),
        .sysrst     (sysrst),
        .load_en    (load_en),
        .word_valid (word_valid),
        .word_data  (word_data),
        .mem_ready  (mem_ready),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .restart    (restart),
        .load_addr  (load_addr),
        .last_word  (last_word)
    );

    // stands in for the board sdram
    program_ram u_program_ram (
        .sysclk    (sysclk),
        .sysrst    (sysrst),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .mem_ready (mem_ready)
    );

    hex_seg_display u_hex_seg_display (
        .load_addr (load_addr),
        .last_word (last_word),
        .hex0      (hex0),
        .hex1      (hex1),
        .hex2      (hex2),
        .hex3      (hex3),
        .hex4      (hex4),
        .hex5      (hex5)
    );

endmodule

/* tests/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic sysclk,
    output logic sysrst
);
    localparam int HALF_PERIOD = 4;
    localparam int RESET_CYCLES = 4;

    initial begin
        sysclk = 1'b0;
        forever #(HALF_PERIOD) sysclk = ~sysclk;
    end

    // reset held low for the first few edges
    initial begin
        sysrst = 1'b0;
        repeat (RESET_CYCLES) @(posedge sysclk);
        sysrst <= 1'b1;
    end

endmodule

/* tests/tb_checker.sv */
`timescale 1ns/1ps

module tb_checker (
    input  logic                              sysclk,
    input  logic                              sysrst,
    input  logic                              mem_ready,
    input  logic [loader_pkg::ADDR_WIDTH-1:0] rd_addr,
    input  logic [loader_pkg::WORD_WIDTH-1:0] rd_data,
    input  logic [7:0]                        hex0,
    input  logic [7:0]                        hex1,
    input  logic [7:0]                        hex2,
    input  logic [7:0]                        hex3,
    input  logic [7:0]                        hex4,
    input  logic [7:0]                        hex5,
    input  logic                              rd_chk,
    input  logic [loader_pkg::WORD_WIDTH-1:0] rd_exp,
    input  logic                              hex_chk,
    input  logic [loader_pkg::ADDR_WIDTH-1:0] exp_addr,
    input  logic [loader_pkg::WORD_WIDTH-1:0] exp_word,
    output int                                error_count,
    output int                                check_count
);
    import loader_pkg::*;

    logic rd_pending;
    logic [ADDR_WIDTH-1:0] pending_addr;
    logic [WORD_WIDTH-1:0] pending_exp;
    logic ready_seen;
    int ready_wait;

    task automatic compare_value(input string name, input logic [15:0] expected,
                                 input logic [15:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERROR at %t: %s expected %h, got %h", $realtime, name, expected, actual);
        end
    endtask

    // dp bit off, segments from the hex table
    task automatic check_digit(input string name, input logic [3:0] nibble,
                               input logic [7:0] actual);
        compare_value(name, {8'h00, 1'b1, SEG_TABLE[nibble]}, {8'h00, actual});
    endtask

    initial begin
        $timeformat(-9, 0, " ns", 0);
        error_count = 0;
        check_count = 0;
    end

    always @(posedge sysclk) begin
        if (!sysrst) begin
            rd_pending = 1'b0;
            ready_seen = 1'b0;
            ready_wait = 0;
        end else begin
            // read data lags the strobe by one cycle
            if (rd_pending) begin
                compare_value($sformatf("rd_data[%02h]", pending_addr), pending_exp, rd_data);
            end
            rd_pending   = rd_chk;
            pending_addr = rd_addr;
            pending_exp  = rd_exp;

            if (mem_ready && !ready_seen) begin
                ready_seen = 1'b1;
                if (ready_wait < RAM_DEPTH) begin
                    error_count++;
                    $display("mem_ready rose after %0d cycles, before the clear could finish",
                             ready_wait);
                end
            end else if (!mem_ready && ready_seen) begin
                error_count++;
                $display("mem_ready fell at %t although reset was not asserted", $realtime);
            end else if (!mem_ready) begin
                ready_wait++;
            end

            if (hex_chk) begin
                check_digit("hex5", exp_addr[7:4], hex5);
                check_digit("hex4", exp_addr[3:0], hex4);
                check_digit("hex3", exp_word[15:12], hex3);
                check_digit("hex2", exp_word[11:8], hex2);
                check_digit("hex1", exp_word[7:4], hex1);
                check_digit("hex0", exp_word[3:0], hex0);
            end
        end
    end

endmodule

/* tests/tb_program_loader.sv */
`timescale 1ns/1ps

module tb_program_loader;
    import loader_pkg::*;

    localparam int ENTRIES = 12;
    localparam int CLK_PERIOD = 8;
    localparam int WATCHDOG_CYCLES = ENTRIES * 20 * CLKS_PER_BIT + 2 * RAM_DEPTH + 1000;

    // load switch, fixed word and random flag per entry
    localparam bit TBL_LOAD [ENTRIES] = '{1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0,
                                         1'b0, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1};
    localparam logic [15:0] TBL_FIXED [ENTRIES] = '{
        16'h1234, 16'habcd, 16'h0000, 16'h0000, 16'hffff, 16'h5a5a,
        16'h0000, 16'h8001, 16'h0000, 16'h00ff, 16'h0000, 16'hc3c3
    };
    localparam bit TBL_RANDOM [ENTRIES] = '{1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0,
                                           1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0};

    logic sysclk;
    logic sysrst;
    logic rx;
    logic load_en;
    logic [ADDR_WIDTH-1:0] rd_addr;
    logic [WORD_WIDTH-1:0] rd_data;
    logic mem_ready;
    logic [7:0] hex0;
    logic [7:0] hex1;
    logic [7:0] hex2;
    logic [7:0] hex3;
    logic [7:0] hex4;
    logic [7:0] hex5;
    logic rd_chk;
    logic [WORD_WIDTH-1:0] rd_exp;
    logic hex_chk;
    logic [ADDR_WIDTH-1:0] exp_addr;
    logic [WORD_WIDTH-1:0] exp_word;
    int error_count;
    int check_count;
    integer seed;
    logic [WORD_WIDTH-1:0] tbl_word [ENTRIES];
    logic [WORD_WIDTH-1:0] model_mem [RAM_DEPTH];
    logic [ADDR_WIDTH-1:0] model_addr;
    logic [WORD_WIDTH-1:0] model_last;
    logic model_load;

    tb_clock u_clock (.sysclk(sysclk), .sysrst(sysrst));

    program_loader uut (
        .sysclk(sysclk), .sysrst(sysrst), .rx(rx), .load_en(load_en),
        .rd_addr(rd_addr), .rd_data(rd_data), .mem_ready(mem_ready),
        .hex0(hex0), .hex1(hex1), .hex2(hex2), .hex3(hex3), .hex4(hex4), .hex5(hex5)
    );

    tb_checker u_checker (
        .sysclk(sysclk), .sysrst(sysrst), .mem_ready(mem_ready), .rd_addr(rd_addr),
        .rd_data(rd_data), .hex0(hex0), .hex1(hex1), .hex2(hex2), .hex3(hex3),
        .hex4(hex4), .hex5(hex5), .rd_chk(rd_chk), .rd_exp(rd_exp), .hex_chk(hex_chk),
        .exp_addr(exp_addr), .exp_word(exp_word), .error_count(error_count),
        .check_count(check_count)
    );

    task automatic send_bit(input logic value);
        rx <= value;
        repeat (CLKS_PER_BIT) @(posedge sysclk);
    endtask

    // 8N1, lsb first
    task automatic send_byte(input logic [7:0] value);
        send_bit(1'b0);
        for (int i = 0; i < 8; i++) begin
            send_bit(value[i]);
        end
        send_bit(1'b1);
    endtask

    task automatic request_hex_check();
        exp_addr <= model_addr;
        exp_word <= model_last;
        hex_chk  <= 1'b1;
        @(posedge sysclk);
        hex_chk <= 1'b0;
    endtask

    task automatic sweep_memory();
        for (int a = 0; a < RAM_DEPTH; a++) begin
            rd_addr <= ADDR_WIDTH'(a);
            rd_exp  <= model_mem[a];
            rd_chk  <= 1'b1;
            @(posedge sysclk);
        end
        rd_chk <= 1'b0;
        repeat (2) @(posedge sysclk);
    endtask

    task automatic apply_entry(input int idx);
        load_en <= TBL_LOAD[idx];
        send_byte(tbl_word[idx][15:8]);
        send_byte(tbl_word[idx][7:0]);
        // idle bit time while the word reaches memory
        send_bit(1'b1);
        if (TBL_LOAD[idx]) begin
            // switch turned on again, back to address zero
            if (!model_load) begin
                model_addr = '0;
            end
            model_mem[model_addr] = tbl_word[idx];
            model_addr = model_addr + ADDR_WIDTH'(1);
            model_last = tbl_word[idx];
        end
        model_load = TBL_LOAD[idx];
        request_hex_check();
    endtask

    initial begin
        seed = 78;
        rx = 1'b1;
        load_en = 1'b0;
        rd_addr = '0;
        rd_chk = 1'b0;
        rd_exp = '0;
        hex_chk = 1'b0;
        exp_addr = '0;
        exp_word = '0;
        model_addr = '0;
        model_last = '0;
        model_load = 1'b0;
        for (int a = 0; a < RAM_DEPTH; a++) begin
            model_mem[a] = '0;
        end
        for (int i = 0; i < ENTRIES; i++) begin
            tbl_word[i] = TBL_RANDOM[i] ? WORD_WIDTH'($random(seed)) : TBL_FIXED[i];
        end
        @(posedge sysclk);
        while (!sysrst) @(posedge sysclk);
        while (!mem_ready) @(posedge sysclk);
        // blank display and a cleared memory first
        request_hex_check();
        sweep_memory();
        for (int i = 0; i < ENTRIES; i++) begin
            apply_entry(i);
        end
        sweep_memory();
        @(posedge sysclk);
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("checks: %0d, errors: %0d", check_count, error_count);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

/* compile.f */
rtl/loader_pkg.sv
rtl/uart_rx.sv
rtl/word_assembler.sv
rtl/load_sequencer.sv
rtl/program_ram.sv
rtl/hex_seg_display.sv
rtl/program_loader.sv
tests/tb_clock.sv
tests/tb_checker.sv
tests/tb_program_loader.sv

/* Makefile */
# Verilator build and run for the program loader testbench

VERILATOR ?= verilator
TOP       ?= tb_program_loader
FILE_LIST ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILE_LIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "NO ERRORS" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
